//--- common/pu_pkg.sv
package pu_pkg;

  parameter int DATA_WIDTH = 32;
  parameter int ATTR_WIDTH = 4;
  parameter int INVALID    = 0; // bit of the attribute word that flags a bad value.

  parameter int FRAM_WORDS = 8;
  parameter int PROG_WORDS = 16;

  typedef logic [DATA_WIDTH-1:0] data_t;
  typedef logic [ATTR_WIDTH-1:0] attr_t;
  typedef logic [2:0]            fram_addr_t;
  typedef logic [3:0]            prog_addr_t;

  // one microprogram word, sixteen bits wide.
  typedef struct packed {
    logic       halt;       // last word of the program.
    logic       div_wr;
    logic       div_wr_sel; // high starts a division.
    logic       div_oe;
    logic       div_oe_sel; // high selects the remainder.
    logic       fram_wr;
    logic       fram_oe;
    fram_addr_t fram_addr;
    logic [5:0] spare;
  } ctrl_word_t;

  typedef enum logic {
    SEQ_IDLE,
    SEQ_RUN
  } seq_state_t;

endpackage

//--- pu_div/div_pipe.sv
`timescale 1ns/1ps

module div_pipe
  import pu_pkg::*;
#(
  parameter int DATA_WIDTH = pu_pkg::DATA_WIDTH,
  parameter int PIPE       = 4
) (
  input  logic  clk,
  input  logic  rst,
  input  data_t numer,
  input  data_t denom,
  output data_t quotient,
  output data_t remain
);

  // DATA_WIDTH has to divide evenly by PIPE.
  localparam int STEPS = DATA_WIDTH / PIPE;

  // nq starts as the numerator. Each step shifts one numerator bit out at
  // the top and one quotient bit in at the bottom.
  typedef struct packed {
    data_t rem;
    data_t nq;
    data_t den;
  } stage_t;

  function automatic stage_t restore_steps(input stage_t st_in);
    stage_t                st;
    logic [DATA_WIDTH:0]   shifted;
    logic                  qbit;
    int                    s;
    st = st_in;
    for (s = 0; s < STEPS; s++) begin
      shifted = {st.rem, st.nq[DATA_WIDTH-1]};
      qbit    = (shifted >= {1'b0, st.den});
      if (qbit) begin
        shifted = shifted - {1'b0, st.den};
      end
      st.nq  = {st.nq[DATA_WIDTH-2:0], qbit};
      st.rem = shifted[DATA_WIDTH-1:0];
    end
    return st;
  endfunction

  for (genvar g = 0; g < PIPE; g++) begin : g_stage
    stage_t st_in;
    stage_t st_q;

    if (g == 0) begin : g_head
      assign st_in = '{rem: '0, nq: numer, den: denom};
    end else begin : g_tail
      assign st_in = g_stage[g-1].st_q;
    end

    always_ff @(posedge clk) begin
      if (rst) begin
        st_q <= '0;
      end else begin
        st_q <= restore_steps(st_in); // denominator rides along unchanged.
      end
    end
  end

  // with a zero denominator every trial succeeds. The quotient fills with
  // ones and the remainder ends up holding the numerator.
  assign quotient = g_stage[PIPE-1].st_q.nq;
  assign remain   = g_stage[PIPE-1].st_q.rem;

endmodule

//--- pu_div/pu_div.sv
`timescale 1ns/1ps

module pu_div
  import pu_pkg::*;
#(
  parameter int DATA_WIDTH = pu_pkg::DATA_WIDTH,
  parameter int ATTR_WIDTH = pu_pkg::ATTR_WIDTH,
  parameter int INVALID    = pu_pkg::INVALID,
  parameter int PIPE       = 4
) (
  input  logic  clk,
  input  logic  rst,
  input  logic  wr,
  input  logic  wr_sel,
  input  logic  oe,
  input  logic  oe_sel,
  input  data_t data_in,
  input  attr_t attr_in,
  output data_t data_out,
  output attr_t attr_out
);

  typedef struct packed {
    data_t value;
    logic  inv;
  } operand_t;

  operand_t      num_latch;
  operand_t      op_a;
  operand_t      op_b;
  operand_t      op_a_d;
  operand_t      op_b_d;
  logic [PIPE:0] inv_pipe;
  data_t         quotient;
  data_t         remain;

  // the numerator waits here until the denominator arrives.
  always_ff @(posedge clk) begin
    if (wr && !wr_sel) begin
      num_latch <= '{value: data_in, inv: attr_in[INVALID]};
    end
  end

  always_comb begin
    op_a_d = op_a;
    op_b_d = op_b;
    if (wr && wr_sel) begin
      op_a_d = num_latch;
      op_b_d = '{value: data_in, inv: attr_in[INVALID]};
    end
  end

  // inv_pipe[0] lines up with the operand registers and inv_pipe[PIPE]
  // with the last divider stage, so flag and result change together.
  always_ff @(posedge clk) begin
    if (rst) begin
      op_a     <= '0;
      op_b     <= '0;
      inv_pipe <= '0;
    end else begin
      op_a     <= op_a_d;
      op_b     <= op_b_d;
      inv_pipe <= {inv_pipe[PIPE-1:0], op_a_d.inv | op_b_d.inv | (op_b_d.value == '0)};
    end
  end

  div_pipe #(
    .DATA_WIDTH (DATA_WIDTH),
    .PIPE       (PIPE)
  ) u_div_pipe (
    .clk      (clk),
    .rst      (rst),
    .numer    (op_a.value),
    .denom    (op_b.value),
    .quotient (quotient),
    .remain   (remain)
  );

  assign data_out = oe ? (oe_sel ? remain : quotient) : '0;

  assign attr_out = oe ? ({{(ATTR_WIDTH-1){1'b0}}, inv_pipe[PIPE]} << INVALID) : '0;

endmodule

//--- run_sim.sh
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --assert -Wno-fatal -f vlog.f --top-module tb_pu_top -o tb_pu_top \
  && ./obj_dir/tb_pu_top > sim.log 2>&1 \
  || { echo "build or simulation did not complete"; cat sim.log 2>/dev/null; exit 1; }

cat sim.log
grep -q "Something failed" sim.log \
  && { echo "RESULT: FAIL"; exit 1; } \
  || { echo "RESULT: PASS"; exit 0; }

//--- sim/tb_pu_top.sv
`timescale 1ns/1ps

module tb_pu_top
  import pu_pkg::*;
;

  localparam int PIPE       = 4;
  localparam int RUNS       = 36;
  localparam int MAX_CYCLES = 40 * RUNS + 200;

  localparam fram_addr_t ADDR_A = 3'd0;
  localparam fram_addr_t ADDR_B = 3'd1;
  localparam fram_addr_t ADDR_Q = 3'd2;
  localparam fram_addr_t ADDR_R = 3'd3;

  logic       clk;
  logic       rst;
  logic       start;
  logic       prog_we;
  logic       host_we;
  logic       host_attr;
  prog_addr_t prog_addr;
  ctrl_word_t prog_word;
  fram_addr_t host_addr;
  fram_addr_t host_raddr;
  data_t      host_data;
  logic       busy;
  logic       done;
  data_t      host_rdata;
  attr_t      host_rattr;

  int seed = 32'h200b;
  int cycles = 0;
  int prog_len = 0;

  pu_top #(
    .DATA_WIDTH (DATA_WIDTH),
    .ATTR_WIDTH (ATTR_WIDTH),
    .INVALID    (INVALID),
    .PIPE       (PIPE)
  ) UUT (
    .clk        (clk),
    .rst        (rst),
    .start      (start),
    .prog_we    (prog_we),
    .host_we    (host_we),
    .host_attr  (host_attr),
    .prog_addr  (prog_addr),
    .prog_word  (prog_word),
    .host_addr  (host_addr),
    .host_raddr (host_raddr),
    .host_data  (host_data),
    .busy       (busy),
    .done       (done),
    .host_rdata (host_rdata),
    .host_rattr (host_rattr)
  );

  always #50 clk = ~clk;

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= MAX_CYCLES) begin
      $display("timeout: the run did not finish within %0d cycles", MAX_CYCLES);
      $display("Something failed");
      $fatal(1);
    end
  end

  task automatic report_mismatch(input string msg);
    $display("mismatch at time %0t: %s", $time, msg);
    $display("Something failed");
    $fatal(1);
  endtask

  function automatic ctrl_word_t make_word(input logic halt, input logic wr, input logic wr_sel,
                                           input logic oe, input logic oe_sel,
                                           input logic fwr, input logic foe,
                                           input fram_addr_t addr);
    ctrl_word_t w;
    w            = '0;
    w.halt       = halt;
    w.div_wr     = wr;
    w.div_wr_sel = wr_sel;
    w.div_oe     = oe;
    w.div_oe_sel = oe_sel;
    w.fram_wr    = fwr;
    w.fram_oe    = foe;
    w.fram_addr  = addr;
    return w;
  endfunction

  task automatic load_word(input int addr, input ctrl_word_t word);
    @(posedge clk);
    prog_we   <= 1'b1;
    prog_addr <= prog_addr_t'(addr);
    prog_word <= word;
    @(posedge clk);
    prog_we   <= 1'b0;
  endtask

  task automatic load_mem(input fram_addr_t addr, input data_t value, input logic inv);
    @(posedge clk);
    host_we   <= 1'b1;
    host_addr <= addr;
    host_data <= value;
    host_attr <= inv;
    @(posedge clk);
    host_we   <= 1'b0;
    host_attr <= 1'b0;
  endtask

  // two operand reads, PIPE+1 idle words, then quotient and remainder back to memory.
  task automatic load_divide_program();
    int pos;
    pos = 0;
    load_word(pos, make_word(0, 1, 0, 0, 0, 0, 1, ADDR_A));
    pos = pos + 1;
    load_word(pos, make_word(0, 1, 1, 0, 0, 0, 1, ADDR_B));
    pos = pos + 1;
    for (int i = 0; i < PIPE + 1; i++) begin
      load_word(pos, '0);
      pos = pos + 1;
    end
    load_word(pos, make_word(0, 0, 0, 1, 0, 1, 0, ADDR_Q));
    pos = pos + 1;
    load_word(pos, make_word(1, 0, 0, 1, 1, 1, 0, ADDR_R));
    pos = pos + 1;
    prog_len = pos;
  endtask

  // restart_at is the edge count at which a second start is pulsed. Zero means none.
  task automatic run_program(input int n_words, input int restart_at);
    int edges;
    edges = 0;
    @(posedge clk);
    start <= 1'b1;
    do begin
      @(posedge clk);
      start <= (restart_at != 0) && (edges == restart_at);
      edges++;
      @(negedge clk);
      if (!done) begin
        assert (busy) else report_mismatch("busy low while the program runs");
      end
    end while (!done);
    assert (edges == n_words + 1)
      else report_mismatch($sformatf("done after %0d edges, expected %0d", edges, n_words + 1));
    @(posedge clk);
    @(negedge clk);
    assert (!done && !busy) else report_mismatch("done longer than one cycle or run restarted");
  endtask

  task automatic check_mem(input fram_addr_t addr, input data_t exp_data, input logic exp_inv);
    attr_t exp_attr;
    exp_attr          = '0;
    exp_attr[INVALID] = exp_inv;
    @(posedge clk);
    host_raddr <= addr;
    @(negedge clk);
    assert (host_rdata == exp_data)
      else report_mismatch($sformatf("word %0d data %h, expected %h", addr, host_rdata, exp_data));
    assert (host_rattr == exp_attr)
      else report_mismatch($sformatf("word %0d attr %h, expected %h", addr, host_rattr, exp_attr));
  endtask

  task automatic divide_and_check(input data_t numer, input data_t denom, input logic numer_inv,
                                  input logic denom_inv, input int restart_at);
    data_t exp_q;
    data_t exp_r;
    logic  exp_inv;
    if (denom == '0) begin
      exp_q = '1; // every trial subtract succeeds.
      exp_r = numer;
    end else begin
      exp_q = numer / denom;
      exp_r = numer % denom;
    end
    exp_inv = numer_inv | denom_inv | (denom == '0);
    load_mem(ADDR_A, numer, numer_inv);
    load_mem(ADDR_B, denom, denom_inv);
    load_mem(ADDR_Q, ~exp_q, 1'b0); // stale contents must not match.
    load_mem(ADDR_R, ~exp_r, 1'b0);
    run_program(prog_len, restart_at);
    check_mem(ADDR_Q, exp_q, exp_inv);
    check_mem(ADDR_R, exp_r, exp_inv);
  endtask

  task automatic test_idle_after_reset();
    repeat (5) begin
      @(negedge clk);
      assert (!busy && !done) else report_mismatch("busy or done active while idle");
    end
    for (int i = 0; i < FRAM_WORDS; i++) begin
      check_mem(fram_addr_t'(i), '0, 1'b0);
    end
    run_program(1, 0); // the empty program store halts on its first word.
    for (int i = 0; i < FRAM_WORDS; i++) begin
      check_mem(fram_addr_t'(i), '0, 1'b0);
    end
  endtask

  task automatic test_random_pairs();
    data_t numer;
    data_t denom;
    data_t shift_raw;
    for (int i = 0; i < 30; i++) begin
      numer     = $random(seed);
      denom     = $random(seed);
      shift_raw = $random(seed);
      denom     = denom >> shift_raw[4:0]; // spreads the quotient sizes.
      if (denom == '0) begin
        denom = 1;
      end
      divide_and_check(numer, denom, 1'b0, 1'b0, 0);
    end
  endtask

  initial begin
    clk        = 1'b0;
    rst        = 1'b1;
    start      = 1'b0;
    prog_we    = 1'b0;
    host_we    = 1'b0;
    host_attr  = 1'b0;
    prog_addr  = '0;
    prog_word  = '0;
    host_addr  = '0;
    host_raddr = '0;
    host_data  = '0;
    repeat (4) @(posedge clk);
    rst <= 1'b0;

    test_idle_after_reset();
    load_divide_program();
    divide_and_check(32'd100, 32'd7, 1'b0, 1'b0, 0);
    divide_and_check(32'd12345, 32'd0, 1'b0, 1'b0, 0);
    divide_and_check(32'd1000, 32'd9, 1'b1, 1'b0, 0);
    divide_and_check(32'd77, 32'd5, 1'b0, 1'b1, 0);
    test_random_pairs();
    divide_and_check(32'd4095, 32'd64, 1'b0, 1'b0, 3);

    $display("Everything OK");
    $finish;
  end

endmodule

//--- src/program_mem.sv
`timescale 1ns/1ps

module program_mem
  import pu_pkg::*;
(
  input  logic       clk,
  input  logic       rst,
  input  logic       prog_we,
  input  prog_addr_t prog_addr,
  input  ctrl_word_t prog_word,
  input  prog_addr_t rd_addr,
  output ctrl_word_t rd_word
);

  // an empty slot stops the sequencer right away.
  localparam ctrl_word_t HALT_WORD = '{halt: 1'b1, default: '0};

  ctrl_word_t mem [PROG_WORDS];

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < PROG_WORDS; i++) begin
        mem[i] <= HALT_WORD;
      end
    end else if (prog_we) begin
      mem[prog_addr] <= prog_word;
    end
  end

  // read is combinational. The sequencer registers the word itself.
  assign rd_word = mem[rd_addr];

endmodule

//--- src/pu_fram.sv
`timescale 1ns/1ps

module pu_fram
  import pu_pkg::*;
#(
  parameter int DATA_WIDTH = pu_pkg::DATA_WIDTH,
  parameter int ATTR_WIDTH = pu_pkg::ATTR_WIDTH
) (
  input  logic       clk,
  input  logic       rst,
  input  logic       wr,
  input  logic       oe,
  input  logic       host_we,
  input  logic       host_attr,
  input  fram_addr_t addr,
  input  fram_addr_t host_addr,
  input  fram_addr_t host_raddr,
  input  data_t      data_in,
  input  data_t      host_data,
  input  attr_t      attr_in,
  output data_t      data_out,
  output data_t      host_rdata,
  output attr_t      attr_out,
  output attr_t      host_rattr
);

  typedef struct packed {
    data_t data;
    attr_t attr;
  } fram_word_t;

  fram_word_t mem [FRAM_WORDS];
  attr_t      host_attr_word;

  // the host can only mark a word invalid or leave its attribute clear.
  assign host_attr_word = {{(ATTR_WIDTH-1){1'b0}}, host_attr} << INVALID;

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < FRAM_WORDS; i++) begin
        mem[i] <= '0;
      end
    end else if (wr) begin
      mem[addr] <= '{data: data_in, attr: attr_in}; // bus side wins a collision.
    end else if (host_we) begin
      mem[host_addr] <= '{data: host_data, attr: host_attr_word};
    end
  end

  assign data_out = oe ? mem[addr].data : '0;
  assign attr_out = oe ? mem[addr].attr : '0;

  assign host_rdata = mem[host_raddr].data;
  assign host_rattr = mem[host_raddr].attr;

endmodule

//--- src/pu_top.sv
`timescale 1ns/1ps

module pu_top
  import pu_pkg::*;
#(
  parameter int DATA_WIDTH = pu_pkg::DATA_WIDTH,
  parameter int ATTR_WIDTH = pu_pkg::ATTR_WIDTH,
  parameter int INVALID    = pu_pkg::INVALID,
  parameter int PIPE       = 4
) (
  input  logic       clk,
  input  logic       rst,
  input  logic       start,
  input  logic       prog_we,
  input  logic       host_we,
  input  logic       host_attr,
  input  prog_addr_t prog_addr,
  input  ctrl_word_t prog_word,
  input  fram_addr_t host_addr,
  input  fram_addr_t host_raddr,
  input  data_t      host_data,
  output logic       busy,
  output logic       done,
  output data_t      host_rdata,
  output attr_t      host_rattr
);

  prog_addr_t rd_addr;
  ctrl_word_t rd_word;
  ctrl_word_t ctrl;
  data_t      div_data;
  data_t      fram_data;
  data_t      data_bus;
  attr_t      div_attr;
  attr_t      fram_attr;
  attr_t      attr_bus;

  // idle units drive zero, so a plain OR is the bus.
  assign data_bus = div_data | fram_data;
  assign attr_bus = div_attr | fram_attr;

  program_mem u_program_mem (
    .clk       (clk),
    .rst       (rst),
    .prog_we   (prog_we),
    .prog_addr (prog_addr),
    .prog_word (prog_word),
    .rd_addr   (rd_addr),
    .rd_word   (rd_word)
  );

  sequencer u_sequencer (
    .clk     (clk),
    .rst     (rst),
    .start   (start),
    .rd_word (rd_word),
    .rd_addr (rd_addr),
    .ctrl    (ctrl),
    .busy    (busy),
    .done    (done)
  );

  pu_div #(
    .DATA_WIDTH (DATA_WIDTH),
    .ATTR_WIDTH (ATTR_WIDTH),
    .INVALID    (INVALID),
    .PIPE       (PIPE)
  ) u_pu_div (
    .clk      (clk),
    .rst      (rst),
    .wr       (ctrl.div_wr),
    .wr_sel   (ctrl.div_wr_sel),
    .oe       (ctrl.div_oe),
    .oe_sel   (ctrl.div_oe_sel),
    .data_in  (data_bus),
    .attr_in  (attr_bus),
    .data_out (div_data),
    .attr_out (div_attr)
  );

  pu_fram #(
    .DATA_WIDTH (DATA_WIDTH),
    .ATTR_WIDTH (ATTR_WIDTH)
  ) u_pu_fram (
    .clk        (clk),
    .rst        (rst),
    .wr         (ctrl.fram_wr),
    .oe         (ctrl.fram_oe),
    .host_we    (host_we),
    .host_attr  (host_attr),
    .addr       (ctrl.fram_addr),
    .host_addr  (host_addr),
    .host_raddr (host_raddr),
    .data_in    (data_bus),
    .host_data  (host_data),
    .attr_in    (attr_bus),
    .data_out   (fram_data),
    .host_rdata (host_rdata),
    .attr_out   (fram_attr),
    .host_rattr (host_rattr)
  );

endmodule

//--- src/sequencer.sv
`timescale 1ns/1ps

module sequencer
  import pu_pkg::*;
(
  input  logic       clk,
  input  logic       rst,
  input  logic       start,
  input  ctrl_word_t rd_word,
  output prog_addr_t rd_addr,
  output ctrl_word_t ctrl,
  output logic       busy,
  output logic       done
);

  seq_state_t state;
  prog_addr_t pc;

  assign rd_addr = pc;
  assign busy    = (state == SEQ_RUN);

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= SEQ_IDLE;
      pc    <= '0;
      ctrl  <= '0;
      done  <= 1'b0;
    end else begin
      done <= 1'b0;
      case (state)
        SEQ_IDLE: begin
          if (start) begin
            ctrl  <= rd_word; // pc sits at zero while idle.
            pc    <= pc + 1'b1;
            state <= SEQ_RUN;
          end
        end
        SEQ_RUN: begin
          // start is not looked at here, so a run cannot be restarted.
          if (ctrl.halt) begin
            ctrl  <= '0;
            pc    <= '0;
            state <= SEQ_IDLE;
            done  <= 1'b1;
          end else begin
            ctrl <= rd_word;
            pc   <= pc + 1'b1;
          end
        end
        default: begin
          state <= SEQ_IDLE;
        end
      endcase
    end
  end

endmodule

//--- vlog.f
common/pu_pkg.sv
src/program_mem.sv
src/sequencer.sv
pu_div/div_pipe.sv
pu_div/pu_div.sv
src/pu_fram.sv
src/pu_top.sv
sim/tb_pu_top.sv
